//--- src.f
hw/core_pkg.sv
hw/bru_pkg.sv
hw/issue_fifo.sv
hw/phy_regfile.sv
hw/bru_issue.sv
hw/bru_execute.sv
hw/bru_top.sv
testbench/bru_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= bru_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- testbench/bru_stim.txt
# Columns: A idx | W idx data | D op rs1 rs2 pc imm exp_taken exp_next_pc | N | R exp_ready
# Values in hex. op: 0 beq, 1 bne, 2 blt, 3 bge, 4 bltu, 5 bgeu.
N
N
# Operand registers, r3 is -2.
W 01 5
W 02 5
W 03 fffffffffffffffe
W 04 3
# All six compares with signed and unsigned edges.
D 0 01 02 1000 40 1 1040
D 1 01 02 1004 40 0 1008
D 2 03 04 2000 fffffffffffffff0 1 1ff0
D 3 03 04 2010 20 0 2014
D 4 03 04 3000 100 0 3004
D 5 03 04 3010 fffffffffffffff8 1 3008
D 3 01 02 4000 8 1 4008
D 4 04 01 4100 10 1 4110
D 2 01 02 4200 10 0 4204
# RAW wait on r5, old value would give not taken.
W 05 7
W 06 10
A 05
D 0 05 06 5000 80 1 5080
N
N
N
W 05 10
# Head blocked on r7 holds back four entries.
A 07
D 1 07 01 6000 20 1 6020
D 0 01 02 6100 30 1 6130
D 4 03 04 6200 40 0 6204
D 5 01 04 6300 40 1 6340
R 0
W 07 9
D 2 03 01 6400 fffffffffffffffc 1 63fc
N
N

//--- testbench/bru_tb.sv
module bru_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import core_pkg::*;
	import bru_pkg::*;

	localparam int IDX_W       = $clog2(PRF_DEPTH_DEFAULT);
	localparam int DRAIN_LIMIT = 64;

	// One parsed line of the stim file.
	typedef struct packed {
		logic [7:0]      kind;
		logic [2:0]      op;
		logic [7:0]      rs1;
		logic [7:0]      rs2;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] data;
		logic            taken;
		logic [XLEN-1:0] next_pc;
	} stim_t;

	logic             CLK;
	logic             rst_n;
	logic             dispatch_valid;
	logic             dispatch_ready;
	bru_issue_info_t  dispatch_info;
	logic             alloc_valid;
	logic [IDX_W-1:0] alloc_index;
	logic             wb_valid;
	logic [IDX_W-1:0] wb_index;
	logic [XLEN-1:0]  wb_data;
	logic             resolve_valid;
	bru_resolve_t     resolve;

	stim_t        stim_q[$];
	bru_resolve_t exp_q[$];
	int           id_q[$];
	int           dispatched = 0;
	int           passed = 0;
	int           failed = 0;
	int           cycles = 0;
	int           limit = 1000;

	bru_top DUT (
		.CLK            (CLK),
		.rst_n          (rst_n),
		.dispatch_valid (dispatch_valid),
		.dispatch_ready (dispatch_ready),
		.dispatch_info  (dispatch_info),
		.alloc_valid    (alloc_valid),
		.alloc_index    (alloc_index),
		.wb_valid       (wb_valid),
		.wb_index       (wb_index),
		.wb_data        (wb_data),
		.resolve_valid  (resolve_valid),
		.resolve        (resolve)
	);

	always #5 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= limit) begin
			$display("Timeout: no end of test after %0d cycles", cycles);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic read_stim();
		int              fd;
		int              code;
		int              c;
		logic            done;
		logic [7:0]      cmd;
		logic [XLEN-1:0] v_op;
		logic [XLEN-1:0] v_rs1;
		logic [XLEN-1:0] v_rs2;
		logic [XLEN-1:0] v_pc;
		logic [XLEN-1:0] v_imm;
		logic [XLEN-1:0] v_data;
		logic [XLEN-1:0] v_taken;
		logic [XLEN-1:0] v_npc;
		stim_t           s;
		fd = $fopen("testbench/bru_stim.txt", "r");
		assert (fd != 0) else begin
			$display("Could not open testbench/bru_stim.txt");
			failed++;
		end
		if (fd == 0) begin
			return;
		end
		done = 1'b0;
		while (!done) begin
			code = $fscanf(fd, " %c", cmd);
			if (code != 1) begin
				done = 1'b1;
			end else begin
				case (cmd)
					"#": begin
						// Skip the rest of a comment line.
						c = $fgetc(fd);
						while (c != 10 && c != -1) begin
							c = $fgetc(fd);
						end
					end
					"A": code = $fscanf(fd, "%h", v_rs1);
					"W": code = $fscanf(fd, "%h %h", v_rs1, v_data);
					"R": code = $fscanf(fd, "%h", v_taken);
					"D": code = $fscanf(fd, "%h %h %h %h %h %h %h",
						v_op, v_rs1, v_rs2, v_pc, v_imm, v_taken, v_npc);
					"N": code = 0;
					default: begin
						$display("Unknown command %s in stim file", cmd);
						failed++;
					end
				endcase
				if (cmd inside {"A", "W", "R", "D", "N"}) begin
					s         = '0;
					s.kind    = cmd;
					s.op      = v_op[2:0];
					s.rs1     = v_rs1[7:0];
					s.rs2     = v_rs2[7:0];
					s.pc      = v_pc;
					s.imm     = v_imm;
					s.data    = v_data;
					s.taken   = v_taken[0];
					s.next_pc = v_npc;
					stim_q.push_back(s);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic drive_cmd(input stim_t s);
		bru_resolve_t exp;
		@(negedge CLK);
		alloc_valid    = 1'b0;
		wb_valid       = 1'b0;
		dispatch_valid = 1'b0;
		case (s.kind)
			"A": begin
				alloc_valid = 1'b1;
				alloc_index = s.rs1[IDX_W-1:0];
			end
			"W": begin
				wb_valid = 1'b1;
				wb_index = s.rs1[IDX_W-1:0];
				wb_data  = s.data;
			end
			"R": begin
				#1;
				assert (dispatch_ready == s.taken) else begin
					$display("Mismatch dispatch_ready: got %h, expected %h",
						dispatch_ready, s.taken);
					failed++;
				end
			end
			"D": begin
				dispatch_valid    = 1'b1;
				dispatch_info.op  = bru_op_e'(s.op);
				dispatch_info.rs1 = s.rs1;
				dispatch_info.rs2 = s.rs2;
				dispatch_info.pc  = s.pc;
				dispatch_info.imm = s.imm;
				// Ready follows registered state only and holds until the edge.
				#1;
				while (!dispatch_ready) begin
					@(negedge CLK);
					#1;
				end
				exp.taken   = s.taken;
				exp.next_pc = s.next_pc;
				exp_q.push_back(exp);
				dispatched++;
				id_q.push_back(dispatched);
			end
			default: ;
		endcase
	endtask

	task automatic check_resolve();
		bru_resolve_t exp;
		int           id;
		logic         ok;
		assert (exp_q.size() != 0) else begin
			$display("Resolve pulse seen with no branch outstanding");
			failed++;
		end
		if (exp_q.size() != 0) begin
			exp = exp_q.pop_front();
			id  = id_q.pop_front();
			ok  = 1'b1;
			assert (resolve.taken == exp.taken) else begin
				$display("Mismatch resolve.taken: got %h, expected %h",
					resolve.taken, exp.taken);
				ok = 1'b0;
			end
			assert (resolve.next_pc == exp.next_pc) else begin
				$display("Mismatch resolve.next_pc: got %h, expected %h",
					resolve.next_pc, exp.next_pc);
				ok = 1'b0;
			end
			if (ok) begin
				passed++;
				$display("Branch %0d ok: taken %0d next_pc %h",
					id, resolve.taken, resolve.next_pc);
			end else begin
				failed++;
				$display("Branch %0d wrong", id);
			end
		end
	endtask

	// Result is registered, so it is stable at the falling edge.
	always @(negedge CLK) begin
		if (rst_n && resolve_valid) begin
			check_resolve();
		end
	end

	initial begin
		int drain;
		CLK            = 1'b0;
		rst_n          = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_info  = '0;
		alloc_valid    = 1'b0;
		alloc_index    = '0;
		wb_valid       = 1'b0;
		wb_index       = '0;
		wb_data        = '0;
		read_stim();
		limit = 8 * stim_q.size() + 200;
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		rst_n = 1'b1;
		#1;
		assert (resolve_valid == 1'b0) else begin
			$display("Mismatch resolve_valid: got %h, expected %h", resolve_valid, 1'b0);
			failed++;
		end
		assert (dispatch_ready == 1'b1) else begin
			$display("Mismatch dispatch_ready: got %h, expected %h", dispatch_ready, 1'b1);
			failed++;
		end
		foreach (stim_q[i]) begin
			drive_cmd(stim_q[i]);
		end
		@(negedge CLK);
		alloc_valid    = 1'b0;
		wb_valid       = 1'b0;
		dispatch_valid = 1'b0;
		drain = 0;
		while (exp_q.size() != 0 && drain < DRAIN_LIMIT) begin
			@(negedge CLK);
			#1;
			drain++;
		end
		assert (exp_q.size() == 0) else begin
			$display("%0d dispatched branches never resolved", exp_q.size());
			failed += exp_q.size();
		end
		$display("Branch checks: %0d passed, %0d failed", passed, failed);
		if (failed == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- hw/bru_top.sv
module bru_top #(
	parameter  int PRF_DEPTH       = core_pkg::PRF_DEPTH_DEFAULT,
	parameter  int BRU_ISSUE_DEPTH = 4,
	localparam int IDX_W           = $clog2(PRF_DEPTH)
) (
	input  logic                      CLK,
	input  logic                      rst_n,

	input  logic                      dispatch_valid,
	output logic                      dispatch_ready,
	input  bru_pkg::bru_issue_info_t  dispatch_info,

	input  logic                      alloc_valid,
	input  logic [IDX_W-1:0]          alloc_index,

	input  logic                      wb_valid,
	input  logic [IDX_W-1:0]          wb_index,
	input  logic [core_pkg::XLEN-1:0] wb_data,

	output logic                      resolve_valid,
	output bru_pkg::bru_resolve_t     resolve
);

	import core_pkg::*;
	import bru_pkg::*;

	logic [IDX_W-1:0] rs1_index;
	logic [IDX_W-1:0] rs2_index;
	logic             rs1_ready;
	logic             rs2_ready;
	logic [XLEN-1:0]  rs1_data;
	logic [XLEN-1:0]  rs2_data;

	logic             exec_valid;
	bru_exec_info_t   exec_info;

	bru_issue #(
		.PRF_DEPTH       (PRF_DEPTH),
		.BRU_ISSUE_DEPTH (BRU_ISSUE_DEPTH)
	) u_bru_issue (
		.CLK            (CLK),
		.rst_n          (rst_n),
		.dispatch_valid (dispatch_valid),
		.dispatch_ready (dispatch_ready),
		.dispatch_info  (dispatch_info),
		.rs1_index      (rs1_index),
		.rs2_index      (rs2_index),
		.rs1_ready      (rs1_ready),
		.rs2_ready      (rs2_ready),
		.rs1_data       (rs1_data),
		.rs2_data       (rs2_data),
		.exec_valid     (exec_valid),
		.exec_info      (exec_info)
	);

	phy_regfile #(
		.PRF_DEPTH (PRF_DEPTH)
	) u_phy_regfile (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.alloc_valid (alloc_valid),
		.alloc_index (alloc_index),
		.wb_valid    (wb_valid),
		.wb_index    (wb_index),
		.wb_data     (wb_data),
		.rs1_index   (rs1_index),
		.rs2_index   (rs2_index),
		.rs1_ready   (rs1_ready),
		.rs2_ready   (rs2_ready),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data)
	);

	bru_execute u_bru_execute (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.exec_valid    (exec_valid),
		.exec_info     (exec_info),
		.resolve_valid (resolve_valid),
		.resolve       (resolve)
	);

endmodule

//--- hw/bru_execute.sv
module bru_execute (
	input  logic                    CLK,
	input  logic                    rst_n,

	input  logic                    exec_valid,
	input  bru_pkg::bru_exec_info_t exec_info,

	output logic                    resolve_valid,
	output bru_pkg::bru_resolve_t   resolve
);

	import core_pkg::*;
	import bru_pkg::*;

	logic            is_eq;
	logic            is_lt;
	logic            is_ltu;
	logic            taken;
	logic [XLEN-1:0] next_pc;

	assign is_eq  = (exec_info.op1 == exec_info.op2);
	assign is_lt  = ($signed(exec_info.op1) < $signed(exec_info.op2));
	assign is_ltu = (exec_info.op1 < exec_info.op2);

	always_comb begin
		case (exec_info.op)
			OP_BEQ:  taken = is_eq;
			OP_BNE:  taken = !is_eq;
			OP_BLT:  taken = is_lt;
			OP_BGE:  taken = !is_lt;
			OP_BLTU: taken = is_ltu;
			OP_BGEU: taken = !is_ltu;
			default: taken = 1'b0;
		endcase
	end

	// imm is already sign-extended by decode.
	assign next_pc = taken ? exec_info.pc + exec_info.imm : exec_info.pc + XLEN'(4);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			resolve_valid <= 1'b0;
		end else begin
			resolve_valid <= exec_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (exec_valid) begin
			resolve.taken   <= taken;
			resolve.next_pc <= next_pc;
		end
	end

	a_op_defined: assert property (@(posedge CLK) disable iff (!rst_n)
		exec_valid |-> exec_info.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU})
		else $error("bru_execute undefined op %0d", exec_info.op);

endmodule

//--- hw/bru_issue.sv
module bru_issue #(
	parameter  int PRF_DEPTH       = 64,
	parameter  int BRU_ISSUE_DEPTH = 4,
	localparam int IDX_W           = $clog2(PRF_DEPTH)
) (
	input  logic                      CLK,
	input  logic                      rst_n,

	input  logic                      dispatch_valid,
	output logic                      dispatch_ready,
	input  bru_pkg::bru_issue_info_t  dispatch_info,

	// Register file lookup for the queue head.
	output logic [IDX_W-1:0]          rs1_index,
	output logic [IDX_W-1:0]          rs2_index,
	input  logic                      rs1_ready,
	input  logic                      rs2_ready,
	input  logic [core_pkg::XLEN-1:0] rs1_data,
	input  logic [core_pkg::XLEN-1:0] rs2_data,

	output logic                      exec_valid,
	output bru_pkg::bru_exec_info_t   exec_info
);

	import bru_pkg::*;

	logic            issue_push;
	logic            issue_pop;
	logic            fifo_full;
	logic            fifo_empty;
	bru_issue_info_t head;

	// A conditional branch cannot retire ahead of older work anyway,
	// so issue stays in order and a blocked head stalls the rest.
	issue_fifo #(
		.DP (BRU_ISSUE_DEPTH),
		.T  (bru_issue_info_t)
	) u_issue_fifo (
		.CLK             (CLK),
		.rst_n           (rst_n),
		.issue_push      (issue_push),
		.issue_pop       (issue_pop),
		.issue_info_push (dispatch_info),
		.issue_info_pop  (head),
		.fifo_full       (fifo_full),
		.fifo_empty      (fifo_empty)
	);

	// Physical index fits in the low bits of the dispatch field.
	assign rs1_index = head.rs1[IDX_W-1:0];
	assign rs2_index = head.rs2[IDX_W-1:0];

	// RAW clear once both sources have written back.
	assign exec_valid = !fifo_empty && rs1_ready && rs2_ready;

	// Execute never stalls, so every valid issue pops.
	assign issue_pop = exec_valid;

	// A full queue still takes a branch when the head leaves this cycle.
	assign dispatch_ready = !fifo_full || issue_pop;
	assign issue_push     = dispatch_valid && dispatch_ready;

	always_comb begin
		exec_info.op  = head.op;
		exec_info.op1 = rs1_data;
		exec_info.op2 = rs2_data;
		exec_info.pc  = head.pc;
		exec_info.imm = head.imm;
	end

endmodule

//--- hw/phy_regfile.sv
module phy_regfile #(
	parameter  int PRF_DEPTH = 64,
	localparam int IDX_W     = $clog2(PRF_DEPTH)
) (
	input  logic                      CLK,
	input  logic                      rst_n,

	// Rename marks a destination as pending.
	input  logic                      alloc_valid,
	input  logic [IDX_W-1:0]          alloc_index,

	input  logic                      wb_valid,
	input  logic [IDX_W-1:0]          wb_index,
	input  logic [core_pkg::XLEN-1:0] wb_data,

	input  logic [IDX_W-1:0]          rs1_index,
	input  logic [IDX_W-1:0]          rs2_index,
	output logic                      rs1_ready,
	output logic                      rs2_ready,
	output logic [core_pkg::XLEN-1:0] rs1_data,
	output logic [core_pkg::XLEN-1:0] rs2_data
);

	import core_pkg::*;

	logic [XLEN-1:0] regs [PRF_DEPTH];

	// Writeback scoreboard, one bit per physical register.
	logic [PRF_DEPTH-1:0] wb_buf;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wb_buf <= '1;
		end else begin
			if (alloc_valid) begin
				wb_buf[alloc_index] <= 1'b0;
			end
			// Writeback comes second so it wins on the same index.
			if (wb_valid) begin
				wb_buf[wb_index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < PRF_DEPTH; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_valid) begin
			regs[wb_index] <= wb_data;
		end
	end

	// No bypass, a write shows up the cycle after.
	assign rs1_ready = wb_buf[rs1_index];
	assign rs2_ready = wb_buf[rs2_index];
	assign rs1_data  = regs[rs1_index];
	assign rs2_data  = regs[rs2_index];

	a_index_range: assert property (@(posedge CLK) disable iff (!rst_n)
		(alloc_valid |-> int'(alloc_index) < PRF_DEPTH) and
		(wb_valid |-> int'(wb_index) < PRF_DEPTH))
		else $error("phy_regfile index out of range");

endmodule

//--- hw/issue_fifo.sv
module issue_fifo #(
	parameter int  DP = 4,
	parameter type T  = logic
) (
	input  logic CLK,
	input  logic rst_n,

	input  logic issue_push,
	input  logic issue_pop,
	input  T     issue_info_push,
	output T     issue_info_pop,

	output logic fifo_full,
	output logic fifo_empty
);

	localparam int PTR_W = (DP > 1) ? $clog2(DP) : 1;
	localparam int CNT_W = $clog2(DP + 1);

	T mem [DP];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// Wrap at DP, which need not be a power of two.
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DP - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign fifo_full  = (count == CNT_W'(DP));
	assign fifo_empty = (count == '0);

	// Head is read straight from storage.
	assign issue_info_pop = mem[rd_ptr];

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (issue_push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (issue_pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({issue_push, issue_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// When full, push and pop share a slot; the pop reads the old entry first.
	always_ff @(posedge CLK) begin
		if (issue_push) begin
			mem[wr_ptr] <= issue_info_push;
		end
	end

	a_no_overflow: assert property (@(posedge CLK) disable iff (!rst_n)
		issue_push && fifo_full |-> issue_pop)
		else $error("issue_fifo push while full without pop");

	a_no_underflow: assert property (@(posedge CLK) disable iff (!rst_n)
		issue_pop |-> !fifo_empty)
		else $error("issue_fifo pop while empty");

endmodule

//--- hw/bru_pkg.sv
package bru_pkg;

	// Physical register index as carried in the dispatch word.
	localparam int PREG_W = 8;

	// Conditional branch kinds handled by the BRU.
	// jal and jalr go to the adder, not here.
	typedef enum logic [2:0] {
		OP_BEQ  = 3'd0,
		OP_BNE  = 3'd1,
		OP_BLT  = 3'd2,
		OP_BGE  = 3'd3,
		OP_BLTU = 3'd4,
		OP_BGEU = 3'd5
	} bru_op_e;

	// Branch as it sits in the issue queue, sources still as indices.
	typedef struct packed {
		bru_op_e                   op;
		logic [PREG_W-1:0]         rs1;
		logic [PREG_W-1:0]         rs2;
		logic [core_pkg::XLEN-1:0] pc;
		logic [core_pkg::XLEN-1:0] imm;
	} bru_issue_info_t;

	// Branch leaving issue, sources replaced by operand values.
	typedef struct packed {
		bru_op_e                   op;
		logic [core_pkg::XLEN-1:0] op1;
		logic [core_pkg::XLEN-1:0] op2;
		logic [core_pkg::XLEN-1:0] pc;
		logic [core_pkg::XLEN-1:0] imm;
	} bru_exec_info_t;

	typedef struct packed {
		logic                      taken;
		logic [core_pkg::XLEN-1:0] next_pc;
	} bru_resolve_t;

endpackage

//--- hw/core_pkg.sv
package core_pkg;

	// Data and address width of the core.
	localparam int XLEN = 64;

	// Physical register count unless the top level overrides it.
	// Index widths are derived per module from the PRF_DEPTH parameter.
	localparam int PRF_DEPTH_DEFAULT = 64;

endpackage
